/* include/phy_rx_settings.svh */
`ifndef PHY_RX_SETTINGS_SVH
`define PHY_RX_SETTINGS_SVH

// lanes delivered by the PIPE receive interface
`define MAX_NUM_LANES 4
// bits per lane word, four bytes at Gen4 and Gen5
`define LANE_DATA_WIDTH 32

// block lock thresholds, counted in beats
`define LOCK_GOOD_BLOCKS 8
`define UNLOCK_BAD_BLOCKS 4
`define LOCK_COUNT_WIDTH 4

`endif

/* hdl/pcie_phy_pkg.sv */
package pcie_phy_pkg;

  // current link data rate
  // gen3 and above carry 128b/130b sync headers
  typedef enum logic [2:0] {
    RATE_GEN1 = 3'd0,
    RATE_GEN2 = 3'd1,
    RATE_GEN3 = 3'd2,
    RATE_GEN4 = 3'd3,
    RATE_GEN5 = 3'd4
  } rate_speed_e;

  // receive block lock state
  typedef enum logic [1:0] {
    // waiting one cycle after reset or a rate change
    ST_LINK_DOWN = 2'd0,
    // counting consecutive good beats
    ST_LOCKING   = 2'd1,
    // locked, counting bad beats
    ST_LINK_UP   = 2'd2
  } link_state_e;

endpackage

/* hdl/sync_header_check.sv */
`timescale 1ns/1ps

`include "phy_rx_settings.svh"

module sync_header_check
  import pcie_phy_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  rate_speed_e                   curr_data_rate_i,
  input  logic [2:0]                    num_active_lanes_i,
  input  logic [`MAX_NUM_LANES-1:0]     data_valid_i,
  input  logic [2*`MAX_NUM_LANES-1:0]   sync_header_i,
  output logic                          good_block_o,
  output logic                          bad_block_o
);

  logic [`MAX_NUM_LANES-1:0] active_valid_c;
  logic [`MAX_NUM_LANES-1:0] lane_ok_c;
  logic                      beat_c;
  logic                      has_headers_c;
  logic                      good_c;
  logic                      bad_c;

  always_comb begin
    for (int lane = 0; lane < `MAX_NUM_LANES; lane++) begin
      active_valid_c[lane] = data_valid_i[lane] && (lane < int'(num_active_lanes_i));
      // legal headers are 01 and 10, so the two bits differ
      lane_ok_c[lane] = !active_valid_c[lane] ||
                        (sync_header_i[2*lane+1] ^ sync_header_i[2*lane]);
    end
    beat_c        = |active_valid_c;
    has_headers_c = (curr_data_rate_i >= RATE_GEN3);
    good_c        = beat_c && (!has_headers_c || (&lane_ok_c));
    bad_c         = beat_c && has_headers_c && !(&lane_ok_c);
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      good_block_o <= 1'b0;
      bad_block_o  <= 1'b0;
    end else begin
      good_block_o <= good_c;
      bad_block_o  <= bad_c;
    end
  end

  // verdict strobes are exclusive
  assert property (@(posedge clk_i) disable iff (rst_i)
    !(good_block_o && bad_block_o));

endmodule

/* hdl/block_lock_counter.sv */
`timescale 1ns/1ps

`include "phy_rx_settings.svh"

module block_lock_counter (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          cnt_inc_i,
  input  logic                          cnt_clear_i,
  output logic [`LOCK_COUNT_WIDTH-1:0]  lock_count_o
);

  logic [`LOCK_COUNT_WIDTH-1:0] count_r;
  logic                         at_max_c;

  // hold at all ones instead of wrapping
  assign at_max_c = (count_r == {`LOCK_COUNT_WIDTH{1'b1}});

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      count_r <= '0;
    end else if (cnt_clear_i) begin
      // clear beats a same-cycle increment
      count_r <= '0;
    end else if (cnt_inc_i && !at_max_c) begin
      count_r <= count_r + 1'b1;
    end
  end

  assign lock_count_o = count_r;

  // only a clear or a reset brings the count down
  assert property (@(posedge clk_i) disable iff (rst_i)
    (!$past(rst_i) && !$past(cnt_clear_i)) |-> (lock_count_o >= $past(lock_count_o)));

endmodule

/* hdl/link_up_fsm.sv */
`timescale 1ns/1ps

`include "phy_rx_settings.svh"

module link_up_fsm
  import pcie_phy_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  rate_speed_e                   curr_data_rate_i,
  input  logic                          good_block_i,
  input  logic                          bad_block_i,
  input  logic [`LOCK_COUNT_WIDTH-1:0]  lock_count_i,
  output logic                          cnt_inc_o,
  output logic                          cnt_clear_o,
  output logic                          link_up_o
);

  link_state_e state_r;
  link_state_e state_c;
  rate_speed_e rate_r;
  logic        rate_change_c;
  logic        link_up_r;

  assign rate_change_c = (curr_data_rate_i != rate_r);

  always_comb begin
    state_c     = state_r;
    cnt_inc_o   = 1'b0;
    cnt_clear_o = 1'b0;
    case (state_r)
      ST_LINK_DOWN: begin
        cnt_clear_o = 1'b1;
        state_c     = ST_LOCKING;
      end
      ST_LOCKING: begin
        // good beats must be consecutive, any bad beat starts over
        cnt_inc_o   = good_block_i;
        cnt_clear_o = bad_block_i;
        if (lock_count_i >= `LOCK_COUNT_WIDTH'(`LOCK_GOOD_BLOCKS)) begin
          // reuse the counter for bad beats once up
          cnt_clear_o = 1'b1;
          state_c     = ST_LINK_UP;
        end
      end
      ST_LINK_UP: begin
        cnt_inc_o = bad_block_i;
        if (lock_count_i >= `LOCK_COUNT_WIDTH'(`UNLOCK_BAD_BLOCKS)) begin
          cnt_clear_o = 1'b1;
          state_c     = ST_LOCKING;
        end
      end
      default: begin
        state_c = ST_LINK_DOWN;
      end
    endcase
    // a rate switch loses lock from any state
    if (rate_change_c) begin
      cnt_clear_o = 1'b1;
      state_c     = ST_LINK_DOWN;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r   <= ST_LINK_DOWN;
      rate_r    <= RATE_GEN1;
      link_up_r <= 1'b0;
    end else begin
      state_r   <= state_c;
      rate_r    <= curr_data_rate_i;
      link_up_r <= (state_c == ST_LINK_UP);
    end
  end

  assign link_up_o = link_up_r;

endmodule

/* hdl/block_alignment.sv */
`timescale 1ns/1ps

`include "phy_rx_settings.svh"

module block_alignment
  import pcie_phy_pkg::*;
(
  input  logic                                         clk_i,
  input  logic                                         rst_i,
  input  logic                                         phy_link_up_i,
  input  logic                                         lane_reverse_i,
  input  rate_speed_e                                  curr_data_rate_i,
  input  logic [2:0]                                   num_active_lanes_i,
  input  logic [`MAX_NUM_LANES*`LANE_DATA_WIDTH-1:0]   data_i,
  input  logic [`MAX_NUM_LANES-1:0]                    data_valid_i,
  input  logic [`MAX_NUM_LANES*`LANE_DATA_WIDTH/8-1:0] data_k_i,
  input  logic [2*`MAX_NUM_LANES-1:0]                  sync_header_i,
  output logic [`MAX_NUM_LANES*`LANE_DATA_WIDTH-1:0]   data_o,
  output logic [`MAX_NUM_LANES-1:0]                    data_valid_o,
  output logic [`MAX_NUM_LANES*`LANE_DATA_WIDTH/8-1:0] data_k_o,
  output logic [2*`MAX_NUM_LANES-1:0]                  sync_header_o
);

  localparam int LaneBytes = `LANE_DATA_WIDTH / 8;

  logic [`MAX_NUM_LANES*`LANE_DATA_WIDTH-1:0] data_c;
  logic [`MAX_NUM_LANES*`LANE_DATA_WIDTH-1:0] data_r;
  logic [`MAX_NUM_LANES-1:0]                  data_valid_c;
  logic [`MAX_NUM_LANES-1:0]                  data_valid_r;
  logic [`MAX_NUM_LANES*LaneBytes-1:0]        data_k_c;
  logic [`MAX_NUM_LANES*LaneBytes-1:0]        data_k_r;
  logic [2*`MAX_NUM_LANES-1:0]                sync_header_c;
  logic [2*`MAX_NUM_LANES-1:0]                sync_header_r;
  logic [`MAX_NUM_LANES-1:0]                  active_mask_c;
  logic [2:0]                                 bytes_per_lane_c;
  int                                         num_lanes_c;

  // pipe width follows the data rate
  always_comb begin
    case (curr_data_rate_i)
      RATE_GEN1: bytes_per_lane_c = 3'd1;
      RATE_GEN2: bytes_per_lane_c = 3'd2;
      RATE_GEN3: bytes_per_lane_c = 3'd2;
      RATE_GEN4: bytes_per_lane_c = 3'd4;
      RATE_GEN5: bytes_per_lane_c = 3'd4;
      default:   bytes_per_lane_c = 3'd1;
    endcase
  end

  always_comb begin
    // out of range lane counts are treated as all lanes
    if (int'(num_active_lanes_i) > `MAX_NUM_LANES) begin
      num_lanes_c = `MAX_NUM_LANES;
    end else begin
      num_lanes_c = int'(num_active_lanes_i);
    end
    for (int lane = 0; lane < `MAX_NUM_LANES; lane++) begin
      active_mask_c[lane] = (lane < num_lanes_c);
    end
  end

  always_comb begin : stripe
    int src;
    int src_byte;
    int slot;
    data_c        = '0;
    data_valid_c  = '0;
    data_k_c      = '0;
    sync_header_c = '0;
    src           = 0;
    src_byte      = 0;
    slot          = 0;
    if (phy_link_up_i && (|data_valid_i)) begin
      for (int lane = 0; lane < `MAX_NUM_LANES; lane++) begin
        if (active_mask_c[lane]) begin
          // mirrored lane when the link trained reversed
          src = lane_reverse_i ? (num_lanes_c - 1 - lane) : lane;
          data_valid_c[lane]       = data_valid_i[src];
          sync_header_c[2*lane+:2] = sync_header_i[2*src+:2];
          for (int b = 0; b < LaneBytes; b++) begin
            if (b < int'(bytes_per_lane_c)) begin
              // last received byte of the lane goes first
              src_byte = int'(bytes_per_lane_c) - 1 - b;
              // byte b of every lane lands in one stripe of the output
              slot = lane + b * num_lanes_c;
              data_c[8*slot+:8] = data_i[`LANE_DATA_WIDTH*src+8*src_byte+:8];
              data_k_c[slot]    = data_k_i[LaneBytes*src+src_byte];
            end
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      data_valid_r <= '0;
    end else begin
      data_valid_r <= data_valid_c;
    end
    data_r        <= data_c;
    data_k_r      <= data_k_c;
    sync_header_r <= sync_header_c;
  end

  assign data_o        = data_r;
  assign data_valid_o  = data_valid_r;
  assign data_k_o      = data_k_r;
  assign sync_header_o = sync_header_r;

  // lanes above the active width never report valid
  assert property (@(posedge clk_i) disable iff (rst_i)
    !$past(rst_i) |-> ((data_valid_o & ~$past(active_mask_c)) == '0));

endmodule

/* hdl/phy_rx_top.sv */
`timescale 1ns/1ps

`include "phy_rx_settings.svh"

module phy_rx_top
  import pcie_phy_pkg::*;
(
  input  logic                                         clk_i,
  input  logic                                         rst_i,
  input  rate_speed_e                                  curr_data_rate_i,
  input  logic                                         lane_reverse_i,
  input  logic [2:0]                                   num_active_lanes_i,
  input  logic [`MAX_NUM_LANES*`LANE_DATA_WIDTH-1:0]   data_i,
  input  logic [`MAX_NUM_LANES-1:0]                    data_valid_i,
  input  logic [`MAX_NUM_LANES*`LANE_DATA_WIDTH/8-1:0] data_k_i,
  input  logic [2*`MAX_NUM_LANES-1:0]                  sync_header_i,
  output logic                                         phy_link_up_o,
  output logic [`MAX_NUM_LANES*`LANE_DATA_WIDTH-1:0]   data_o,
  output logic [`MAX_NUM_LANES-1:0]                    data_valid_o,
  output logic [`MAX_NUM_LANES*`LANE_DATA_WIDTH/8-1:0] data_k_o,
  output logic [2*`MAX_NUM_LANES-1:0]                  sync_header_o
);

  logic                         good_block;
  logic                         bad_block;
  logic                         cnt_inc;
  logic                         cnt_clear;
  logic [`LOCK_COUNT_WIDTH-1:0] lock_count;
  logic                         link_up;

  sync_header_check u_sync_header_check (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .curr_data_rate_i   (curr_data_rate_i),
    .num_active_lanes_i (num_active_lanes_i),
    .data_valid_i       (data_valid_i),
    .sync_header_i      (sync_header_i),
    .good_block_o       (good_block),
    .bad_block_o        (bad_block)
  );

  block_lock_counter u_block_lock_counter (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .cnt_inc_i    (cnt_inc),
    .cnt_clear_i  (cnt_clear),
    .lock_count_o (lock_count)
  );

  link_up_fsm u_link_up_fsm (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .curr_data_rate_i (curr_data_rate_i),
    .good_block_i     (good_block),
    .bad_block_i      (bad_block),
    .lock_count_i     (lock_count),
    .cnt_inc_o        (cnt_inc),
    .cnt_clear_o      (cnt_clear),
    .link_up_o        (link_up)
  );

  block_alignment u_block_alignment (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .phy_link_up_i      (link_up),
    .lane_reverse_i     (lane_reverse_i),
    .curr_data_rate_i   (curr_data_rate_i),
    .num_active_lanes_i (num_active_lanes_i),
    .data_i             (data_i),
    .data_valid_i       (data_valid_i),
    .data_k_i           (data_k_i),
    .sync_header_i      (sync_header_i),
    .data_o             (data_o),
    .data_valid_o       (data_valid_o),
    .data_k_o           (data_k_o),
    .sync_header_o      (sync_header_o)
  );

  assign phy_link_up_o = link_up;

endmodule

/* test/tb_phy_rx_top.sv */
`timescale 1ns/1ps

`include "phy_rx_settings.svh"

module tb_phy_rx_top
  import pcie_phy_pkg::*;
();

  logic                                         clk;
  logic                                         rst;
  rate_speed_e                                  rate;
  logic                                         lane_reverse;
  logic [2:0]                                   num_lanes;
  logic [`MAX_NUM_LANES*`LANE_DATA_WIDTH-1:0]   data;
  logic [`MAX_NUM_LANES-1:0]                    valid;
  logic [`MAX_NUM_LANES*`LANE_DATA_WIDTH/8-1:0] data_k;
  logic [2*`MAX_NUM_LANES-1:0]                  sync_header;
  logic                                         link_up;
  logic [`MAX_NUM_LANES*`LANE_DATA_WIDTH-1:0]   data_out;
  logic [`MAX_NUM_LANES-1:0]                    valid_out;
  logic [`MAX_NUM_LANES*`LANE_DATA_WIDTH/8-1:0] k_out;
  logic [2*`MAX_NUM_LANES-1:0]                  sh_out;

  // reference model state
  link_state_e                                  m_state;
  rate_speed_e                                  m_rate;
  logic [`LOCK_COUNT_WIDTH-1:0]                 m_count;
  logic                                         m_good;
  logic                                         m_bad;
  logic                                         m_link_up;
  logic [`MAX_NUM_LANES*`LANE_DATA_WIDTH-1:0]   m_data;
  logic [`MAX_NUM_LANES-1:0]                    m_valid;
  logic [`MAX_NUM_LANES*`LANE_DATA_WIDTH/8-1:0] m_k;
  logic [2*`MAX_NUM_LANES-1:0]                  m_sh;

  integer seed;
  int     bad_pct;
  logic   all_valid;
  logic   rev_random;
  logic   aborted;
  int     error_count;
  int     timeout_count;
  int     check_count;

  phy_rx_top phy_rx_top_i (
    .clk_i              (clk),
    .rst_i              (rst),
    .curr_data_rate_i   (rate),
    .lane_reverse_i     (lane_reverse),
    .num_active_lanes_i (num_lanes),
    .data_i             (data),
    .data_valid_i       (valid),
    .data_k_i           (data_k),
    .sync_header_i      (sync_header),
    .phy_link_up_o      (link_up),
    .data_o             (data_out),
    .data_valid_o       (valid_out),
    .data_k_o           (k_out),
    .sync_header_o      (sh_out)
  );

  always #50 clk = ~clk;

  function automatic int lane_bytes(input rate_speed_e r);
    if (r == RATE_GEN1) return 1;
    if (r == RATE_GEN4 || r == RATE_GEN5) return 4;
    return 2;
  endfunction

  // legal 128b/130b headers are 01 and 10
  function automatic logic [1:0] pick_header();
    if (($unsigned($random(seed)) % 100) < bad_pct) begin
      return ($random(seed) & 1) ? 2'b11 : 2'b00;
    end
    return ($random(seed) & 1) ? 2'b10 : 2'b01;
  endfunction

  task automatic drive_beat();
    data   = {$random(seed), $random(seed), $random(seed), $random(seed)};
    data_k = $random(seed);
    valid  = all_valid ? '1 : $random(seed);
    if (rev_random) begin
      lane_reverse = $random(seed) & 1;
    end
    for (int l = 0; l < `MAX_NUM_LANES; l++) begin
      sync_header[2*l+:2] = pick_header();
    end
  endtask

  // expected striped word for the beat now on the inputs
  task automatic predict_aligned(output logic [`MAX_NUM_LANES*`LANE_DATA_WIDTH-1:0] d,
                                 output logic [`MAX_NUM_LANES-1:0] v,
                                 output logic [`MAX_NUM_LANES*`LANE_DATA_WIDTH/8-1:0] k,
                                 output logic [2*`MAX_NUM_LANES-1:0] sh);
    int n;
    int nb;
    int src;
    int slot;
    d  = '0;
    v  = '0;
    k  = '0;
    sh = '0;
    n  = int'(num_lanes);
    nb = lane_bytes(rate);
    if (m_link_up && (valid != '0)) begin
      for (int l = 0; l < n; l++) begin
        src = lane_reverse ? (n - 1 - l) : l;
        v[l] = valid[src];
        sh[2*l+:2] = sync_header[2*src+:2];
        for (int b = 0; b < nb; b++) begin
          slot = l + b * n;
          d[8*slot+:8] = data[`LANE_DATA_WIDTH*src + 8*(nb-1-b) +: 8];
          k[slot] = data_k[(`LANE_DATA_WIDTH/8)*src + nb - 1 - b];
        end
      end
    end
  endtask

  task automatic update_model();
    link_state_e                  ns;
    logic [`LOCK_COUNT_WIDTH-1:0] nc;
    logic                         beat;
    logic                         all_legal;
    ns = m_state;
    nc = m_count;
    predict_aligned(m_data, m_valid, m_k, m_sh);
    if (rate != m_rate) begin
      ns = ST_LINK_DOWN;
      nc = '0;
    end else if (m_state == ST_LINK_DOWN) begin
      ns = ST_LOCKING;
      nc = '0;
    end else if (m_state == ST_LOCKING) begin
      if (m_count >= `LOCK_GOOD_BLOCKS) begin
        ns = ST_LINK_UP;
        nc = '0;
      end else if (m_bad) begin
        nc = '0;
      end else if (m_good && m_count != '1) begin
        nc = m_count + 1'b1;
      end
    end else if (m_count >= `UNLOCK_BAD_BLOCKS) begin
      ns = ST_LOCKING;
      nc = '0;
    end else if (m_bad && m_count != '1) begin
      nc = m_count + 1'b1;
    end
    // header verdict for this beat, seen by the lock rule next cycle
    beat      = 1'b0;
    all_legal = 1'b1;
    for (int l = 0; l < int'(num_lanes); l++) begin
      if (valid[l]) begin
        beat = 1'b1;
        if (!(sync_header[2*l+:2] inside {2'b01, 2'b10})) all_legal = 1'b0;
      end
    end
    if (rst) begin
      m_state   = ST_LINK_DOWN;
      m_rate    = RATE_GEN1;
      m_count   = '0;
      m_good    = 1'b0;
      m_bad     = 1'b0;
      m_link_up = 1'b0;
      m_valid   = '0;
    end else begin
      m_state   = ns;
      m_rate    = rate;
      m_count   = nc;
      m_good    = beat && (rate < RATE_GEN3 || all_legal);
      m_bad     = beat && rate >= RATE_GEN3 && !all_legal;
      m_link_up = (ns == ST_LINK_UP);
    end
  endtask

  task automatic check_outputs();
    check_count++;
    assert (link_up === m_link_up) else begin
      $display("ERROR at %0t: link up is %b, model expects %b", $time, link_up, m_link_up);
      error_count++;
    end
    assert (valid_out === m_valid) else begin
      $display("ERROR at %0t: valid is %h, model expects %h", $time, valid_out, m_valid);
      error_count++;
    end
    assert (data_out === m_data && k_out === m_k) else begin
      $display("ERROR at %0t: data %h k %h, model expects data %h k %h",
               $time, data_out, k_out, m_data, m_k);
      error_count++;
    end
    assert (sh_out === m_sh) else begin
      $display("ERROR at %0t: sync header %b, model expects %b", $time, sh_out, m_sh);
      error_count++;
    end
  endtask

  // one clock; inputs change 10 ns after the edge, right after the check
  task automatic step();
    @(posedge clk);
    update_model();
    #10;
    if (!rst) check_outputs();
  endtask

  task automatic run_beats(input int count);
    for (int i = 0; i < count; i++) begin
      if (aborted) return;
      drive_beat();
      step();
    end
  endtask

  task automatic wait_link(input logic level, input int limit, input string what);
    int cycles;
    cycles = 0;
    if (aborted) return;
    while (link_up !== level && cycles < limit) begin
      drive_beat();
      step();
      cycles++;
    end
    if (link_up !== level) begin
      $display("timed out after %0d cycles waiting for %s, lock FSM in %s",
               cycles, what, phy_rx_top_i.u_link_up_fsm.state_r.name());
      timeout_count++;
      aborted = 1'b1;
    end
  endtask

  initial begin
    int widths [3];
    widths        = '{1, 2, 4};
    seed          = 1298;
    error_count   = 0;
    timeout_count = 0;
    check_count   = 0;
    aborted       = 1'b0;
    bad_pct       = 0;
    all_valid     = 1'b1;
    rev_random    = 1'b0;
    clk           = 1'b0;
    rst           = 1'b1;
    rate          = RATE_GEN3;
    lane_reverse  = 1'b0;
    num_lanes     = 3'd4;
    data          = '0;
    valid         = '0;
    data_k        = '0;
    sync_header   = '0;
    m_link_up     = 1'b0;
    repeat (3) step();
    rst = 1'b0;

    // lock at gen3 on legal headers
    wait_link(1'b1, 100, "link up at gen3");
    run_beats(20);

    // bad headers while up, then a noisy relock
    bad_pct = 100;
    wait_link(1'b0, 20, "link drop on bad headers");
    bad_pct = 5;
    run_beats(60);
    bad_pct = 0;
    wait_link(1'b1, 200, "relock after noisy headers");

    // striping at every rate, four lanes
    for (int r = 0; r <= 4; r++) begin
      rate = rate_speed_e'(r);
      wait_link(1'b0, 10, "link drop on rate switch");
      wait_link(1'b1, 100, "link up after rate switch");
      run_beats(30);
    end

    // lane reversal and narrower links at gen5
    rev_random = 1'b1;
    all_valid  = 1'b0;
    foreach (widths[i]) begin
      num_lanes = 3'(widths[i]);
      run_beats(40);
    end

    // rate change while up, then gen1 relocks on valid beats alone
    rev_random = 1'b0;
    all_valid  = 1'b1;
    num_lanes  = 3'd4;
    rate       = RATE_GEN2;
    wait_link(1'b0, 10, "link drop on rate change");
    run_beats(4);
    rate    = RATE_GEN1;
    bad_pct = 100;
    wait_link(1'b1, 100, "relock at gen1");
    run_beats(10);

    $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+include
hdl/pcie_phy_pkg.sv
hdl/sync_header_check.sv
hdl/block_lock_counter.sv
hdl/link_up_fsm.sv
hdl/block_alignment.sv
hdl/phy_rx_top.sv
test/tb_phy_rx_top.sv

/* Makefile */
# Verilator build and run for the PCIe receive lane alignment stage

VERILATOR ?= verilator
TOP       ?= tb_phy_rx_top
RTL_TOP   ?= phy_rx_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing
PASS_TEXT := >>> PASS

SOURCES := $(FILELIST) $(wildcard include/*.svh hdl/*.sv test/*.sv)

.PHONY: all build sim lint clean

all: sim

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q -- '$(PASS_TEXT)' $(LOG) || (echo "simulation did not pass, see $(LOG)" && exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
